// File: rtl/clkCtlPkg.sv
package clkCtlPkg;

  // Bus and counter widths
  localparam int DataWidth  = 16;
  localparam int BurstWidth = 8;
  localparam int AdrWidth   = 3;

  // Register map
  localparam logic [AdrWidth-1:0] AdrFunc   = 3'd0;
  localparam logic [AdrWidth-1:0] AdrBurst  = 3'd1;
  localparam logic [AdrWidth-1:0] AdrRate   = 3'd2;
  localparam logic [AdrWidth-1:0] AdrCheck  = 3'd3; // Also clears latched errors
  localparam logic [AdrWidth-1:0] AdrStatus = 3'd4;
  localparam logic [AdrWidth-1:0] AdrTicks  = 3'd5;

  // Function codes written to AdrFunc, others ignored
  typedef enum logic [2:0] {
    FuncStart = 3'd1,
    FuncStep  = 3'd2,
    FuncBurst = 3'd5,
    FuncHalt  = 3'd6
  } diagFuncT;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AdrWidth-1:0]  adr;
    logic [DataWidth-1:0] dat;
  } wbReqT;

  typedef struct packed {
    logic                 ack;
    logic [DataWidth-1:0] dat;
  } wbRspT;

  // One-cycle command pulses to the sequencer
  typedef struct packed {
    logic                  start;
    logic                  step;
    logic                  burst;
    logic                  halt;
    logic                  loadBurst;
    logic [BurstWidth-1:0] burstCount;
    logic                  loadRate;
    logic [1:0]            rate;
  } seqCmdT;

  typedef struct packed {
    logic       load;
    logic [3:0] enables;   // FM, CRAM, DRAM, field check
    logic       errStopEn;
  } checkCfgT;

  typedef struct packed {
    logic       running;
    logic       stepPending;
    logic       burstActive;
    logic       errorStop;
    logic [3:0] errors;
    logic [1:0] rate;
    logic [5:0] pad;
  } statusT;

endpackage

// File: rtl/diagBusPort.sv
`timescale 1ns/1ps

module diagBusPort #(
  parameter int TickCountWidth = 16
) (
  input  logic                      CLK,
  input  logic                      rstN,
  input  clkCtlPkg::wbReqT          wbReq,
  output clkCtlPkg::wbRspT          wbRsp,
  output clkCtlPkg::seqCmdT         seqCmd,
  output clkCtlPkg::checkCfgT       checkCfg,
  input  clkCtlPkg::statusT         status,
  input  logic [TickCountWidth-1:0] tickCount
);

  localparam int Dw = clkCtlPkg::DataWidth;
  localparam int Bw = clkCtlPkg::BurstWidth;

  logic          ack;
  logic [Dw-1:0] rdDat;
  logic [Dw-1:0] rdSel;
  logic [Dw-1:0] ticksRd;
  logic          access;
  logic          wrAccess;
  logic          rdAccess;
  clkCtlPkg::seqCmdT   seqCmdNext;
  clkCtlPkg::checkCfgT checkCfgNext;

  assign access   = wbReq.cyc & wbReq.stb & ~ack; // First cycle of a transfer
  assign wrAccess = access & wbReq.we;
  assign rdAccess = access & ~wbReq.we;

  assign ticksRd = Dw'(tickCount); // Zero-extend or truncate

  always_comb begin
    case (wbReq.adr)
      clkCtlPkg::AdrStatus: rdSel = status;
      clkCtlPkg::AdrTicks:  rdSel = ticksRd;
      default:              rdSel = '0;
    endcase
  end

  // Write decode into command pulses
  always_comb begin
    seqCmdNext   = '0;
    checkCfgNext = '0;
    if (wrAccess) begin
      case (wbReq.adr)
        clkCtlPkg::AdrFunc: begin
          case (wbReq.dat[2:0])
            clkCtlPkg::FuncStart: seqCmdNext.start = 1'b1;
            clkCtlPkg::FuncStep:  seqCmdNext.step  = 1'b1;
            clkCtlPkg::FuncBurst: seqCmdNext.burst = 1'b1;
            clkCtlPkg::FuncHalt:  seqCmdNext.halt  = 1'b1;
            default: ;
          endcase
        end
        clkCtlPkg::AdrBurst: begin
          seqCmdNext.loadBurst  = 1'b1;
          seqCmdNext.burstCount = wbReq.dat[Bw-1:0];
        end
        clkCtlPkg::AdrRate: begin
          seqCmdNext.loadRate = 1'b1;
          seqCmdNext.rate     = wbReq.dat[1:0];
        end
        clkCtlPkg::AdrCheck: begin
          checkCfgNext.load      = 1'b1;
          checkCfgNext.enables   = wbReq.dat[3:0];
          checkCfgNext.errStopEn = wbReq.dat[4];
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      ack      <= 1'b0;
      seqCmd   <= '0;
      checkCfg <= '0;
    end else begin
      ack      <= access;
      seqCmd   <= seqCmdNext;
      checkCfg <= checkCfgNext;
    end
  end

  always_ff @(posedge CLK) begin
    if (rdAccess) rdDat <= rdSel;
  end

  assign wbRsp.ack = ack;
  assign wbRsp.dat = rdDat;

endmodule

// File: rtl/gateSequencer.sv
`timescale 1ns/1ps

module gateSequencer (
  input  logic              CLK,
  input  logic              rstN,
  input  clkCtlPkg::seqCmdT seqCmd,
  input  logic              tickTaken,
  output logic              tickReq,
  output logic              running,
  output logic              stepPending,
  output logic              burstActive,
  output logic [1:0]        rate
);

  localparam int Bw = clkCtlPkg::BurstWidth;

  logic [2:0]    divCnt;     // Free-running, never cleared by commands
  logic          strobe;
  logic [Bw-1:0] burstReg;
  logic [Bw-1:0] burstLeft;

  // One strobe every 2^rate cycles
  always_comb begin
    case (rate)
      2'd0:    strobe = 1'b1;
      2'd1:    strobe = ~divCnt[0];
      2'd2:    strobe = divCnt[1:0] == 2'b00;
      default: strobe = divCnt == 3'b000;
    endcase
  end

  assign burstActive = burstLeft != '0;
  assign tickReq     = strobe & (running | stepPending | burstActive);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 3'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      rate     <= 2'd0;
      burstReg <= '0;
    end else begin
      if (seqCmd.loadRate) rate <= seqCmd.rate;
      if (seqCmd.loadBurst) burstReg <= seqCmd.burstCount;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      running     <= 1'b0;
      stepPending <= 1'b0;
      burstLeft   <= '0;
    end else begin
      if (tickTaken) begin
        stepPending <= 1'b0;
        if (burstActive) burstLeft <= burstLeft - 1'b1;
      end

      // New commands win over a tick on the same edge
      if (seqCmd.start) running <= 1'b1;
      if (seqCmd.step) stepPending <= 1'b1;
      if (seqCmd.burst) burstLeft <= burstReg; // Zero count issues nothing

      if (seqCmd.halt) begin
        running     <= 1'b0;
        stepPending <= 1'b0;
        burstLeft   <= '0;
      end
    end
  end

endmodule

// File: rtl/parityErrorMonitor.sv
`timescale 1ns/1ps

module parityErrorMonitor (
  input  logic                CLK,
  input  logic                rstN,
  input  clkCtlPkg::checkCfgT checkCfg,
  input  logic [3:0]          parErr,
  input  logic                tickTaken,
  output logic [3:0]          errors,
  output logic                errorStop
);

  logic [3:0] enables;
  logic       errStopEn;
  logic [3:0] errorsNext;

  // Sticky flags, sampled only on issued ticks
  always_comb begin
    errorsNext = errors;
    if (tickTaken) errorsNext = errors | (parErr & enables);
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      enables   <= '0;
      errStopEn <= 1'b0;
    end else if (checkCfg.load) begin
      enables   <= checkCfg.enables;
      errStopEn <= checkCfg.errStopEn;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      errors    <= '0;
      errorStop <= 1'b0;
    end else if (checkCfg.load) begin
      errors    <= '0;  // Check write clears errors
      errorStop <= 1'b0;
    end else begin
      errors    <= errorsNext;
      errorStop <= errStopEn & (|errorsNext);
    end
  end

endmodule

// File: rtl/clockGateMerge.sv
`timescale 1ns/1ps

module clockGateMerge #(
  parameter int TickCountWidth = 16
) (
  input  logic                      CLK,
  input  logic                      rstN,
  input  logic                      tickReq,
  input  logic                      errorStop,
  input  logic [3:0]                errors,
  input  logic                      running,
  input  logic                      stepPending,
  input  logic                      burstActive,
  input  logic [1:0]                rate,
  output logic                      tickTaken,
  output logic                      ceOut,
  output logic [TickCountWidth-1:0] tickCount,
  output clkCtlPkg::statusT         status
);

  // Refused requests stay pending in the sequencer
  assign tickTaken = tickReq & ~errorStop;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      ceOut     <= 1'b0;
      tickCount <= '0;
    end else begin
      ceOut <= tickTaken;
      if (tickTaken) tickCount <= tickCount + 1'b1; // Wraps
    end
  end

  always_comb begin
    status             = '0;
    status.running     = running;
    status.stepPending = stepPending;
    status.burstActive = burstActive;
    status.errorStop   = errorStop;
    status.errors      = errors;
    status.rate        = rate;
  end

endmodule

// File: rtl/clkCtlTop.sv
`timescale 1ns/1ps

module clkCtlTop #(
  parameter int TickCountWidth = 16
) (
  input  logic              CLK,
  input  logic              rstN,
  input  clkCtlPkg::wbReqT  wbReq,
  output clkCtlPkg::wbRspT  wbRsp,
  input  logic [3:0]        parErr,
  output logic              ceOut
);

  clkCtlPkg::seqCmdT   seqCmd;
  clkCtlPkg::checkCfgT checkCfg;
  clkCtlPkg::statusT   status;
  logic [TickCountWidth-1:0] tickCount;
  logic       tickReq;
  logic       tickTaken;
  logic       running;
  logic       stepPending;
  logic       burstActive;
  logic [1:0] rate;
  logic [3:0] errors;
  logic       errorStop;

  diagBusPort #(.TickCountWidth(TickCountWidth)) busPort (
    .CLK       (CLK),
    .rstN      (rstN),
    .wbReq     (wbReq),
    .wbRsp     (wbRsp),
    .seqCmd    (seqCmd),
    .checkCfg  (checkCfg),
    .status    (status),
    .tickCount (tickCount)
  );

  gateSequencer sequencer (
    .CLK         (CLK),
    .rstN        (rstN),
    .seqCmd      (seqCmd),
    .tickTaken   (tickTaken),
    .tickReq     (tickReq),
    .running     (running),
    .stepPending (stepPending),
    .burstActive (burstActive),
    .rate        (rate)
  );

  parityErrorMonitor parMon (
    .CLK       (CLK),
    .rstN      (rstN),
    .checkCfg  (checkCfg),
    .parErr    (parErr),
    .tickTaken (tickTaken),
    .errors    (errors),
    .errorStop (errorStop)
  );

  clockGateMerge #(.TickCountWidth(TickCountWidth)) gateMerge (
    .CLK         (CLK),
    .rstN        (rstN),
    .tickReq     (tickReq),
    .errorStop   (errorStop),
    .errors      (errors),
    .running     (running),
    .stepPending (stepPending),
    .burstActive (burstActive),
    .rate        (rate),
    .tickTaken   (tickTaken),
    .ceOut       (ceOut),
    .tickCount   (tickCount),
    .status      (status)
  );

endmodule

// File: testbench/clkCtlTb_chk.sv
`timescale 1ns/1ps

module clkCtlTbChk (
  input logic CLK,
  input logic rstN,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic tickTaken,
  input logic errorStop,
  input logic ceOut
);

  ackUnderReq: assert property (@(posedge CLK) disable iff (!rstN) ack |-> cyc && stb)
    else $error("ack raised without cyc and stb");

  ackOneCycle: assert property (@(posedge CLK) disable iff (!rstN) ack |=> !ack)
    else $error("ack held for more than one cycle");

  // Refused while stopped
  noTickInStop: assert property (@(posedge CLK) disable iff (!rstN) tickTaken |-> !errorStop)
    else $error("tick granted during error stop");

  ceFollowsTick: assert property (@(posedge CLK) disable iff (!rstN) ceOut == $past(tickTaken))
    else $error("ceOut does not follow tickTaken by one cycle");

endmodule

// Bus port and gate merge signals all meet at the top level
bind clkCtlTop clkCtlTbChk ctlChk (
  .CLK(CLK), .rstN(rstN), .cyc(wbReq.cyc), .stb(wbReq.stb), .ack(wbRsp.ack),
  .tickTaken(tickTaken), .errorStop(errorStop), .ceOut(ceOut)
);

// File: testbench/clkCtlTb.sv
`timescale 1ns/1ps

module clkCtlTb;

  logic             CLK;
  logic             rstN;
  clkCtlPkg::wbReqT wbReq;
  clkCtlPkg::wbRspT wbRsp;
  logic [3:0]       parErr;
  logic             ceOut;

  byte unsigned cmdQ[$];
  int unsigned  argA[$];
  int unsigned  argB[$];
  int unsigned  cycleLimit = 0;
  int unsigned  cycles = 0;
  logic [15:0]  pulseCount;   // Reference tick count

  clkCtlTop #(.TickCountWidth(16)) uut (
    .CLK(CLK), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp), .parErr(parErr), .ceOut(ceOut)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    if (!rstN) pulseCount <= '0;
    else if (ceOut) pulseCount <= pulseCount + 16'd1;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycleLimit != 0 && cycles >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      stopRun();
    end
  end

  task automatic stopRun();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      stopRun();
    end
  endtask

  // Holds cyc and stb until ack
  task automatic busXfer(input logic we, input logic [2:0] adr, input logic [15:0] dat,
                         output logic [15:0] rd);
    clkCtlPkg::wbReqT req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    @(posedge CLK);
    wbReq <= req;
    @(posedge CLK);
    while (!wbRsp.ack) @(posedge CLK);
    rd = wbRsp.dat;
    wbReq <= '0;
  endtask

  // Window opens on the first pulse, or counts 0 if none comes
  task automatic countPulses(input int unsigned window, output int cnt);
    int unsigned waited;
    cnt    = 0;
    waited = 0;
    while (cnt == 0 && waited < window) begin
      @(posedge CLK);
      waited++;
      if (ceOut) cnt = 1;
    end
    if (cnt == 1) begin
      repeat (window - 1) begin
        @(posedge CLK);
        if (ceOut) cnt++;
      end
    end
  endtask

  task automatic waitIdle(input int unsigned polls);
    clkCtlPkg::statusT st;
    int unsigned n;
    n  = 0;
    st = '1;
    while (st.running || st.stepPending || st.burstActive) begin
      if (n == polls) begin
        $display("Sequencer still busy after %0d status polls", polls);
        stopRun();
      end
      busXfer(1'b0, clkCtlPkg::AdrStatus, 16'h0, st);
      n++;
    end
  endtask

  task automatic loadStim();
    int fd;
    int code;
    logic [63:0] tok;
    logic [8*128-1:0] rest;
    int unsigned a;
    int unsigned b;
    fd = $fopen("testbench/clkCtlStim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file testbench/clkCtlStim.txt");
      stopRun();
    end
    cycleLimit = 8;   // Reset
    while ($fscanf(fd, "%s", tok) == 1) begin
      a = 0;
      b = 0;
      case (tok)
        "#": code = $fgets(rest, fd);
        "W", "R", "C": begin
          code = $fscanf(fd, "%h %h", a, b);
          if (code != 2) begin
            $display("Missing arguments for command %s in stimulus file", tok);
            stopRun();
          end
          cmdQ.push_back(tok[7:0]);
          argA.push_back(a);
          argB.push_back(b);
          cycleLimit += (tok == "C") ? 2 * a : 64;
        end
        "P", "I": begin
          code = $fscanf(fd, "%h", a);
          if (code != 1) begin
            $display("Missing argument for command %s in stimulus file", tok);
            stopRun();
          end
          cmdQ.push_back(tok[7:0]);
          argA.push_back(a);
          argB.push_back(0);
          cycleLimit += (tok == "I") ? 64 * a : 1;
        end
        default: begin
          $display("Unknown command in stimulus file: %s", tok);
          stopRun();
        end
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    logic [15:0] rd;
    int cnt;
    rstN   = 1'b0;
    wbReq  = '0;
    parErr = '0;
    loadStim();
    repeat (3) @(posedge CLK);
    rstN <= 1'b1;
    for (int i = 0; i < cmdQ.size(); i++) begin
      case (cmdQ[i])
        "W": busXfer(1'b1, argA[i][2:0], argB[i][15:0], rd);
        "R": begin
          busXfer(1'b0, argA[i][2:0], 16'h0, rd);
          if (argA[i][2:0] == clkCtlPkg::AdrTicks) checkValue(rd, pulseCount, "tick count read");
          else checkValue(rd, argB[i][15:0], $sformatf("read of address %0d", argA[i]));
        end
        "P": begin
          @(posedge CLK);
          parErr <= argA[i][3:0];
        end
        "C": begin
          countPulses(argA[i], cnt);
          checkValue(cnt[15:0], argB[i][15:0], $sformatf("pulses in %0d cycles", argA[i]));
        end
        default: waitIdle(argA[i]);
      endcase
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: sim.f
rtl/clkCtlPkg.sv
rtl/diagBusPort.sv
rtl/gateSequencer.sv
rtl/parityErrorMonitor.sv
rtl/clockGateMerge.sv
rtl/clkCtlTop.sv
testbench/clkCtlTb_chk.sv
testbench/clkCtlTb.sv

// File: Makefile
# Verilator build and run for the clock-control testbench
VERILATOR  ?= verilator
TOP        ?= clkCtlTb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the pass text in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/clkCtlStim.txt
# cmd arg1 arg2 with all numbers in hex
# W adr dat / R adr expected / P parErr / C window pulses / I polls
# R 5 is checked against the testbench pulse count
R 4 0000
R 6 0000
W 7 ffff
R 7 0000
W 2 0
W 0 1
C 20 20
W 0 6
I 10
W 2 1
W 0 1
C 20 10
W 0 6
I 10
W 2 2
W 0 1
C 20 8
W 0 6
I 10
W 2 3
W 0 1
C 20 4
R 4 80c0
W 0 6
I 10
R 5 0
# step and bursts at rate 0
W 2 0
W 0 2
C 10 1
I 10
W 1 5
W 0 5
C 10 5
I 10
W 1 0
W 0 5
C 10 0
R 4 0000
# parity with bit 0 enabled
W 3 01
W 0 1
P 2
C 10 10
R 4 8000
P 1
R 4 8100
W 3 13
R 4 9100
C 10 0
W 0 6
W 0 2
R 4 5100
C 10 0
P 0
W 3 00
C 10 1
I 10
R 4 0000
R 5 0
